// ==== logic/core_glob_regs.sv ====
//////////////////////////////
// Global register block
// Build id, channel count and the board control word
// Answers reads one cycle after the request
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module core_glob_regs (
  input  wire                                       bus_clk,
  input  wire                                       bus_rst,
  // Write strobe with address and data
  input  wire                                       i_wr_req,
  input  wire  [radio_core_pkg::REG_AWIDTH-1:0]     i_wr_addr,
  input  wire  [radio_core_pkg::REG_DWIDTH-1:0]     i_wr_data,
  // Read strobe and one-cycle response
  input  wire                                       i_rd_req,
  input  wire  [radio_core_pkg::REG_AWIDTH-1:0]     i_rd_addr,
  output logic                                      o_rd_resp,
  output logic [radio_core_pkg::REG_DWIDTH-1:0]     o_rd_data,
  // Board controls
  output logic [radio_core_pkg::SPI_MUX_WIDTH-1:0]  o_spi_mux,
  output logic                                      o_cpld_reset,
  output logic [radio_core_pkg::NUM_CHAN-1:0]       o_conj_en
);

  radio_core_pkg::ctrl_word_u             ctrl_q;
  logic                                   rd_hit;
  logic [radio_core_pkg::REG_DWIDTH-1:0]  rd_mux;

  //////////////////////////////
  // Control word
  //////////////////////////////
  // Loaded whole on a write hit
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      ctrl_q.raw <= radio_core_pkg::CTRL_RESET;
    end else if (i_wr_req && (i_wr_addr == radio_core_pkg::REG_CTRL)) begin
      ctrl_q.raw <= i_wr_data;
    end
  end

  // Outputs straight from the stored fields
  assign o_spi_mux    = ctrl_q.fields.spi_mux;
  assign o_cpld_reset = ctrl_q.fields.cpld_reset;
  assign o_conj_en    = ctrl_q.fields.conj_en;

  //////////////////////////////
  // Readback
  //////////////////////////////
  // Address decode where unmapped addresses give no hit
  always_comb begin
    rd_hit = 1'b1;
    rd_mux = '0;
    case (i_rd_addr)
      radio_core_pkg::REG_GIT_HASH: rd_mux = radio_core_pkg::BUILD_ID;
      radio_core_pkg::REG_NUM_CE:   rd_mux = radio_core_pkg::REG_DWIDTH'(radio_core_pkg::NUM_CHAN);
      radio_core_pkg::REG_CTRL:     rd_mux = ctrl_q.raw;
      default:                      rd_hit = 1'b0;
    endcase
  end

  // Response pulse lasts a single cycle
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_rd_resp <= 1'b0;
    end else begin
      o_rd_resp <= i_rd_req && rd_hit;
    end
  end

  // Read data captured with the request
  always_ff @(posedge bus_clk) begin
    if (i_rd_req) begin
      o_rd_data <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// ==== logic/iq_frontend.sv ====
//////////////////////////////
// Receive channel front end
// Swaps I and Q, optionally negates the new Q
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module iq_frontend (
  input  wire                                     bus_clk,
  input  wire                                     bus_rst,
  // Conjugate enable from the control word
  input  wire                                     i_conj,
  // Incoming sample and strobe
  input  wire  [radio_core_pkg::SAMP_WIDTH-1:0]   i_data,
  input  wire                                     i_stb,
  // Swapped sample, one cycle later
  output logic [radio_core_pkg::SAMP_WIDTH-1:0]   o_data,
  output logic                                    o_stb
);

  logic [radio_core_pkg::HALF_WIDTH-1:0] i_half;
  logic [radio_core_pkg::HALF_WIDTH-1:0] q_half;
  logic [radio_core_pkg::HALF_WIDTH-1:0] new_q;

  // Split the incoming word
  assign i_half = i_data[radio_core_pkg::SAMP_WIDTH-1 -: radio_core_pkg::HALF_WIDTH];
  assign q_half = i_data[radio_core_pkg::HALF_WIDTH-1:0];

  // Old I becomes the new Q
  // Two's complement negate with the most negative value wrapping to itself
  assign new_q = i_conj ? (~i_half + 1'b1) : i_half;

  // Strobe delay
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_stb <= 1'b0;
    end else begin
      o_stb <= i_stb;
    end
  end

  // Sample held between strobes
  always_ff @(posedge bus_clk) begin
    if (i_stb) begin
      o_data <= {q_half, new_q};
    end
  end

endmodule

`default_nettype wire

// ==== logic/radio_core_pkg.sv ====
//////////////////////////////
// Shared widths, register map and reset values of the radio core
// Referenced by scoped name from the RTL and the testbench
//////////////////////////////

`default_nettype none

package radio_core_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int REG_AWIDTH    = 14;
  localparam int REG_DWIDTH    = 32;
  // Sample word holds I in the upper half and Q in the lower half
  localparam int SAMP_WIDTH    = 32;
  localparam int HALF_WIDTH    = SAMP_WIDTH / 2;
  localparam int NUM_CHAN      = 4;
  localparam int ROUTE_WIDTH   = 2;
  localparam int SPI_MUX_WIDTH = 3;

  //////////////////////////////
  // Register map
  //////////////////////////////
  localparam logic [REG_AWIDTH-1:0] REG_GIT_HASH   = 14'h0;
  localparam logic [REG_AWIDTH-1:0] REG_NUM_CE     = 14'h4;
  localparam logic [REG_AWIDTH-1:0] REG_CTRL       = 14'h8;
  // Route register k sits at base plus 4*k
  localparam logic [REG_AWIDTH-1:0] REG_ROUTE_BASE = 14'h10;

  // Fixed identifier and control word after reset
  localparam logic [REG_DWIDTH-1:0] BUILD_ID   = 32'h5AC0_0310;
  localparam logic [REG_DWIDTH-1:0] CTRL_RESET = 32'h2;

  // Control word seen whole or split into its fields
  // spi_mux in the low bits, then cpld_reset, then one conj bit per channel
  typedef union packed {
    logic [REG_DWIDTH-1:0] raw;
    struct packed {
      logic [REG_DWIDTH-NUM_CHAN-SPI_MUX_WIDTH-2:0] reserved;
      logic [NUM_CHAN-1:0]                          conj_en;
      logic                                         cpld_reset;
      logic [SPI_MUX_WIDTH-1:0]                     spi_mux;
    } fields;
  } ctrl_word_u;

endpackage

`default_nettype wire

// ==== logic/radio_core_top.sv ====
//////////////////////////////
// Radio core top level
// Register port, four receive front ends and the sample router
// Samples and registers all run on bus_clk
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module radio_core_top (
  input  wire                                                               bus_clk,
  input  wire                                                               bus_rst,
  // Register port
  input  wire                                                               i_reg_wr_req,
  input  wire  [radio_core_pkg::REG_AWIDTH-1:0]                             i_reg_wr_addr,
  input  wire  [radio_core_pkg::REG_DWIDTH-1:0]                             i_reg_wr_data,
  input  wire                                                               i_reg_rd_req,
  input  wire  [radio_core_pkg::REG_AWIDTH-1:0]                             i_reg_rd_addr,
  output wire                                                               o_reg_rd_resp,
  output wire  [radio_core_pkg::REG_DWIDTH-1:0]                             o_reg_rd_data,
  // Receive samples
  input  wire  [radio_core_pkg::NUM_CHAN-1:0][radio_core_pkg::SAMP_WIDTH-1:0] i_rx_data,
  input  wire  [radio_core_pkg::NUM_CHAN-1:0]                               i_rx_stb,
  // Transmit samples
  output wire  [radio_core_pkg::NUM_CHAN-1:0][radio_core_pkg::SAMP_WIDTH-1:0] o_tx_data,
  output wire  [radio_core_pkg::NUM_CHAN-1:0]                               o_tx_stb,
  // Board controls
  output wire  [radio_core_pkg::SPI_MUX_WIDTH-1:0]                          o_spi_mux,
  output wire                                                               o_cpld_reset
);

  wire                                                                glob_rd_resp;
  wire [radio_core_pkg::REG_DWIDTH-1:0]                               glob_rd_data;
  wire                                                                route_rd_resp;
  wire [radio_core_pkg::REG_DWIDTH-1:0]                               route_rd_data;
  wire [radio_core_pkg::NUM_CHAN-1:0]                                 conj_en;
  wire [radio_core_pkg::NUM_CHAN-1:0][radio_core_pkg::SAMP_WIDTH-1:0] fe_data;
  wire [radio_core_pkg::NUM_CHAN-1:0]                                 fe_stb;

  //////////////////////////////
  // Registers
  //////////////////////////////
  core_glob_regs u_core_glob_regs (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .i_wr_req     (i_reg_wr_req),
    .i_wr_addr    (i_reg_wr_addr),
    .i_wr_data    (i_reg_wr_data),
    .i_rd_req     (i_reg_rd_req),
    .i_rd_addr    (i_reg_rd_addr),
    .o_rd_resp    (glob_rd_resp),
    .o_rd_data    (glob_rd_data),
    .o_spi_mux    (o_spi_mux),
    .o_cpld_reset (o_cpld_reset),
    .o_conj_en    (conj_en)
  );

  // Adds the second read cycle
  regport_resp_mux u_regport_resp_mux (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .i_glob_resp  (glob_rd_resp),
    .i_glob_data  (glob_rd_data),
    .i_route_resp (route_rd_resp),
    .i_route_data (route_rd_data),
    .o_rd_resp    (o_reg_rd_resp),
    .o_rd_data    (o_reg_rd_data)
  );

  //////////////////////////////
  // Sample path
  //////////////////////////////
  // One front end per channel with its own conj bit
  for (genvar ch = 0; ch < radio_core_pkg::NUM_CHAN; ch++) begin : g_frontend
    iq_frontend u_iq_frontend (
      .bus_clk (bus_clk),
      .bus_rst (bus_rst),
      .i_conj  (conj_en[ch]),
      .i_data  (i_rx_data[ch]),
      .i_stb   (i_rx_stb[ch]),
      .o_data  (fe_data[ch]),
      .o_stb   (fe_stb[ch])
    );
  end

  sample_router u_sample_router (
    .bus_clk   (bus_clk),
    .bus_rst   (bus_rst),
    .i_wr_req  (i_reg_wr_req),
    .i_wr_addr (i_reg_wr_addr),
    .i_wr_data (i_reg_wr_data),
    .i_rd_req  (i_reg_rd_req),
    .i_rd_addr (i_reg_rd_addr),
    .o_rd_resp (route_rd_resp),
    .o_rd_data (route_rd_data),
    .i_data    (fe_data),
    .i_stb     (fe_stb),
    .o_data    (o_tx_data),
    .o_stb     (o_tx_stb)
  );

endmodule

`default_nettype wire

// ==== logic/regport_resp_mux.sv ====
//////////////////////////////
// Read response merge
// Registers whichever block answered
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module regport_resp_mux (
  input  wire                                     bus_clk,
  input  wire                                     bus_rst,
  // Global register block response
  input  wire                                     i_glob_resp,
  input  wire  [radio_core_pkg::REG_DWIDTH-1:0]   i_glob_data,
  // Router response
  input  wire                                     i_route_resp,
  input  wire  [radio_core_pkg::REG_DWIDTH-1:0]   i_route_data,
  // Merged response, one cycle later
  output logic                                    o_rd_resp,
  output logic [radio_core_pkg::REG_DWIDTH-1:0]   o_rd_data
);

  logic [radio_core_pkg::REG_DWIDTH-1:0] data_or;

  // Address ranges never overlap
  // So an AND-OR merge is enough
  assign data_or = ({radio_core_pkg::REG_DWIDTH{i_glob_resp}} & i_glob_data) |
                   ({radio_core_pkg::REG_DWIDTH{i_route_resp}} & i_route_data);

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_rd_resp <= 1'b0;
      o_rd_data <= '0;
    end else begin
      o_rd_resp <= i_glob_resp | i_route_resp;
      // Data only moves with a response
      if (i_glob_resp || i_route_resp) begin
        o_rd_data <= data_or;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/sample_router.sv ====
//////////////////////////////
// Sample router with route-select registers
// Each transmit output picks one receive channel
// Route registers read back zero-extended
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module sample_router (
  input  wire                                                               bus_clk,
  input  wire                                                               bus_rst,
  // Register write port
  input  wire                                                               i_wr_req,
  input  wire  [radio_core_pkg::REG_AWIDTH-1:0]                             i_wr_addr,
  input  wire  [radio_core_pkg::REG_DWIDTH-1:0]                             i_wr_data,
  // Register read port
  input  wire                                                               i_rd_req,
  input  wire  [radio_core_pkg::REG_AWIDTH-1:0]                             i_rd_addr,
  output logic                                                              o_rd_resp,
  output logic [radio_core_pkg::REG_DWIDTH-1:0]                             o_rd_data,
  // Samples from the front ends
  input  wire  [radio_core_pkg::NUM_CHAN-1:0][radio_core_pkg::SAMP_WIDTH-1:0] i_data,
  input  wire  [radio_core_pkg::NUM_CHAN-1:0]                               i_stb,
  // Routed samples to the transmit side
  output logic [radio_core_pkg::NUM_CHAN-1:0][radio_core_pkg::SAMP_WIDTH-1:0] o_data,
  output logic [radio_core_pkg::NUM_CHAN-1:0]                               o_stb
);

  logic [radio_core_pkg::ROUTE_WIDTH-1:0] route_q [radio_core_pkg::NUM_CHAN];
  logic [radio_core_pkg::NUM_CHAN-1:0]    wr_hit;
  logic [radio_core_pkg::NUM_CHAN-1:0]    rd_hit;
  logic [radio_core_pkg::REG_DWIDTH-1:0]  rd_mux;

  // Address of route register k
  function automatic logic [radio_core_pkg::REG_AWIDTH-1:0] route_addr(input int k);
    route_addr = radio_core_pkg::REG_ROUTE_BASE + radio_core_pkg::REG_AWIDTH'(4 * k);
  endfunction

  //////////////////////////////
  // Route registers
  //////////////////////////////
  // Per-register address decode and readback mux
  always_comb begin
    rd_mux = '0;
    for (int k = 0; k < radio_core_pkg::NUM_CHAN; k++) begin
      wr_hit[k] = i_wr_addr == route_addr(k);
      rd_hit[k] = i_rd_addr == route_addr(k);
      if (rd_hit[k]) begin
        rd_mux = radio_core_pkg::REG_DWIDTH'(route_q[k]);
      end
    end
  end

  // Reset puts each output on its own channel
  always_ff @(posedge bus_clk) begin
    for (int k = 0; k < radio_core_pkg::NUM_CHAN; k++) begin
      if (bus_rst) begin
        route_q[k] <= radio_core_pkg::ROUTE_WIDTH'(k);
      end else if (i_wr_req && wr_hit[k]) begin
        // Only the low bits are kept
        route_q[k] <= i_wr_data[radio_core_pkg::ROUTE_WIDTH-1:0];
      end
    end
  end

  // One-cycle read response
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_rd_resp <= 1'b0;
    end else begin
      o_rd_resp <= i_rd_req && (|rd_hit);
    end
  end

  always_ff @(posedge bus_clk) begin
    if (i_rd_req) begin
      o_rd_data <= rd_mux;
    end
  end

  //////////////////////////////
  // Channel selector
  //////////////////////////////
  // Strobes follow the current route every cycle
  always_ff @(posedge bus_clk) begin
    for (int k = 0; k < radio_core_pkg::NUM_CHAN; k++) begin
      if (bus_rst) begin
        o_stb[k] <= 1'b0;
      end else begin
        o_stb[k] <= i_stb[route_q[k]];
      end
    end
  end

  // Words follow the same selection
  always_ff @(posedge bus_clk) begin
    for (int k = 0; k < radio_core_pkg::NUM_CHAN; k++) begin
      o_data[k] <= i_data[route_q[k]];
    end
  end

endmodule

`default_nettype wire

// ==== radio_core_top.f ====
+incdir+verification
logic/radio_core_pkg.sv
logic/core_glob_regs.sv
logic/iq_frontend.sv
logic/sample_router.sv
logic/regport_resp_mux.sv
logic/radio_core_top.sv
verification/radio_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the radio core testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module radio_core_tb -f radio_core_top.f \
  -Mdir obj_dir -o radio_core_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/radio_core_sim > sim.log 2>&1
cat sim.log
grep -qx "Finished with no errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== verification/radio_core_vectors.svh ====
//////////////////////////////
// Register port vectors for the radio core testbench
// Included once at file scope and walked in order by the table loop
//////////////////////////////

`ifndef RADIO_CORE_VECTORS_SVH
`define RADIO_CORE_VECTORS_SVH

`default_nettype none

// Write, read with response, read expecting silence
localparam logic [1:0] OP_WR = 2'd0;
localparam logic [1:0] OP_RD = 2'd1;
localparam logic [1:0] OP_NR = 2'd2;

typedef struct packed {
  logic [1:0]                            op;
  logic [radio_core_pkg::REG_AWIDTH-1:0] addr;
  logic [radio_core_pkg::REG_DWIDTH-1:0] data;
  logic [radio_core_pkg::REG_DWIDTH-1:0] exp_data;
} reg_vec_t;

localparam int NUM_VEC = 19;

// Each entry holds operation, address, write data and expected read data
localparam reg_vec_t VEC_TABLE [NUM_VEC] = '{
  // Reset values
  '{OP_RD, radio_core_pkg::REG_CTRL,     32'h0000_0000, 32'h0000_0002},
  '{OP_RD, 14'h0010,                     32'h0000_0000, 32'h0000_0000},
  '{OP_RD, 14'h0014,                     32'h0000_0000, 32'h0000_0001},
  '{OP_RD, 14'h0018,                     32'h0000_0000, 32'h0000_0002},
  '{OP_RD, 14'h001C,                     32'h0000_0000, 32'h0000_0003},
  // Constants
  '{OP_RD, radio_core_pkg::REG_GIT_HASH, 32'h0000_0000, 32'h5AC0_0310},
  '{OP_RD, radio_core_pkg::REG_NUM_CE,   32'h0000_0000, 32'h0000_0004},
  // spi_mux 5, cpld_reset 1, conj on channels 1 and 3
  '{OP_WR, radio_core_pkg::REG_CTRL,     32'hC0DE_00AD, 32'h0000_0000},
  '{OP_RD, radio_core_pkg::REG_CTRL,     32'h0000_0000, 32'hC0DE_00AD},
  // Holes in the map
  '{OP_NR, 14'h0030,                     32'h0000_0000, 32'h0000_0000},
  '{OP_NR, 14'h000C,                     32'h0000_0000, 32'h0000_0000},
  // Outputs 0 and 1 share channel 3
  '{OP_WR, 14'h0010,                     32'h0000_0003, 32'h0000_0000},
  '{OP_WR, 14'h0014,                     32'h0000_0007, 32'h0000_0000},
  '{OP_WR, 14'h0018,                     32'hFFFF_FFF1, 32'h0000_0000},
  '{OP_WR, 14'h001C,                     32'h0000_0000, 32'h0000_0000},
  '{OP_RD, 14'h0010,                     32'h0000_0000, 32'h0000_0003},
  '{OP_RD, 14'h0014,                     32'h0000_0000, 32'h0000_0003},
  '{OP_RD, 14'h0018,                     32'h0000_0000, 32'h0000_0001},
  '{OP_RD, 14'h001C,                     32'h0000_0000, 32'h0000_0000}
};

`default_nettype wire

`endif

// ==== verification/radio_core_tb.sv ====
//////////////////////////////
// Testbench for the radio core top level
// Register table first, then a random sample burst
//////////////////////////////

`timescale 1ns/100ps
`include "radio_core_vectors.svh"
`default_nettype none

module radio_core_tb;

  localparam int RESET_CYCLES = 16;
  localparam int READ_WAIT    = 8;
  localparam int NUM_SAMP     = 40;
  // Worst case per entry is a full read window plus the burst and some slack
  localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_VEC * (READ_WAIT + 2) + NUM_SAMP + 40;

  logic                                                               bus_clk;
  logic                                                               bus_rst;
  logic                                                               i_reg_wr_req;
  logic [radio_core_pkg::REG_AWIDTH-1:0]                              i_reg_wr_addr;
  logic [radio_core_pkg::REG_DWIDTH-1:0]                              i_reg_wr_data;
  logic                                                               i_reg_rd_req;
  logic [radio_core_pkg::REG_AWIDTH-1:0]                              i_reg_rd_addr;
  logic [radio_core_pkg::NUM_CHAN-1:0][radio_core_pkg::SAMP_WIDTH-1:0] i_rx_data;
  logic [radio_core_pkg::NUM_CHAN-1:0]                                i_rx_stb;
  wire                                                                o_reg_rd_resp;
  wire  [radio_core_pkg::REG_DWIDTH-1:0]                              o_reg_rd_data;
  wire  [radio_core_pkg::NUM_CHAN-1:0][radio_core_pkg::SAMP_WIDTH-1:0] o_tx_data;
  wire  [radio_core_pkg::NUM_CHAN-1:0]                                o_tx_stb;
  wire  [radio_core_pkg::SPI_MUX_WIDTH-1:0]                           o_spi_mux;
  wire                                                                o_cpld_reset;

  // Reference state that follows the writes issued
  radio_core_pkg::ctrl_word_u             ctrl_model;
  logic [radio_core_pkg::ROUTE_WIDTH-1:0] route_model [radio_core_pkg::NUM_CHAN];
  // Expected outputs three slots deep for the 2-cycle path
  logic [radio_core_pkg::NUM_CHAN-1:0]    hist_stb  [3];
  logic [radio_core_pkg::SAMP_WIDTH-1:0]  hist_data [3][radio_core_pkg::NUM_CHAN];
  integer                                 seed;
  int                                     errors;
  int                                     cycle_cnt;

  radio_core_top u_radio_core_top (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .i_reg_wr_req  (i_reg_wr_req),
    .i_reg_wr_addr (i_reg_wr_addr),
    .i_reg_wr_data (i_reg_wr_data),
    .i_reg_rd_req  (i_reg_rd_req),
    .i_reg_rd_addr (i_reg_rd_addr),
    .o_reg_rd_resp (o_reg_rd_resp),
    .o_reg_rd_data (o_reg_rd_data),
    .i_rx_data     (i_rx_data),
    .i_rx_stb      (i_rx_stb),
    .o_tx_data     (o_tx_data),
    .o_tx_stb      (o_tx_stb),
    .o_spi_mux     (o_spi_mux),
    .o_cpld_reset  (o_cpld_reset)
  );

  initial begin
    bus_clk = 1'b0;
    forever #5 bus_clk = ~bus_clk;
  end

  // New I is old Q and new Q is old I, negated on conj
  function automatic logic [31:0] swap_iq(input logic [31:0] word, input logic conj);
    logic [15:0] new_i;
    logic [15:0] new_q;
    new_i = word[15:0];
    new_q = word[31:16];
    if (conj) begin
      new_q = 16'h0000 - new_q;
    end
    return {new_i, new_q};
  endfunction

  //////////////////////////////
  // Register operations
  //////////////////////////////
  // Entered just after a rising edge
  task automatic apply_vector(input reg_vec_t v);
    int n;
    int first;
    int hits;
    first = 0;
    hits  = 0;
    if (v.op == OP_WR) begin
      i_reg_wr_req  <= 1'b1;
      i_reg_wr_addr <= v.addr;
      i_reg_wr_data <= v.data;
      @(posedge bus_clk);
      i_reg_wr_req <= 1'b0;
      if (v.addr == radio_core_pkg::REG_CTRL) begin
        ctrl_model.raw = v.data;
      end
      for (n = 0; n < radio_core_pkg::NUM_CHAN; n++) begin
        if (v.addr == radio_core_pkg::REG_ROUTE_BASE + radio_core_pkg::REG_AWIDTH'(4 * n)) begin
          route_model[n] = v.data[radio_core_pkg::ROUTE_WIDTH-1:0];
        end
      end
      // Board controls follow one cycle on
      @(negedge bus_clk);
      if (o_spi_mux !== ctrl_model.fields.spi_mux) begin
        errors++;
        $display("[ERROR] o_spi_mux: expected %h got %h", ctrl_model.fields.spi_mux, o_spi_mux);
      end
      if (o_cpld_reset !== ctrl_model.fields.cpld_reset) begin
        errors++;
        $display("[ERROR] o_cpld_reset: expected %h got %h",
                 ctrl_model.fields.cpld_reset, o_cpld_reset);
      end
    end else begin
      i_reg_rd_req  <= 1'b1;
      i_reg_rd_addr <= v.addr;
      // Watch a fixed window and note when and how long resp is high
      for (n = 1; n <= READ_WAIT; n++) begin
        @(posedge bus_clk);
        i_reg_rd_req <= 1'b0;
        @(negedge bus_clk);
        if (o_reg_rd_resp === 1'b1) begin
          hits++;
          if (first == 0) begin
            first = n;
            if (v.op == OP_RD && o_reg_rd_data !== v.exp_data) begin
              errors++;
              $display("[ERROR] o_reg_rd_data at %h: expected %h got %h",
                       v.addr, v.exp_data, o_reg_rd_data);
            end
          end
        end
        // No rx strobe in this phase
        if (o_tx_stb !== '0) begin
          errors++;
          $display("[ERROR] o_tx_stb: expected %h got %h", 4'h0, o_tx_stb);
        end
      end
      if (v.op == OP_RD && hits == 0) begin
        errors++;
        $display("Read of address %h got no response within %0d cycles", v.addr, READ_WAIT);
      end else if (v.op == OP_RD && (first != 2 || hits != 1)) begin
        errors++;
        $display("Read of address %h answered after %0d cycles and stayed high %0d cycles",
                 v.addr, first, hits);
      end
      if (v.op == OP_NR && hits != 0) begin
        errors++;
        $display("Read of unmapped address %h got a response", v.addr);
      end
    end
  endtask

  //////////////////////////////
  // Sample burst
  //////////////////////////////
  task automatic run_samples();
    int n;
    int k;
    int slot;
    logic [radio_core_pkg::NUM_CHAN-1:0]                                stb;
    logic [radio_core_pkg::NUM_CHAN-1:0][radio_core_pkg::SAMP_WIDTH-1:0] words;
    for (n = 0; n < 3; n++) begin
      hist_stb[n] = '0;
    end
    for (n = 0; n < NUM_SAMP + 2; n++) begin
      @(posedge bus_clk);
      slot = n % 3;
      stb  = '0;
      for (k = 0; k < radio_core_pkg::NUM_CHAN; k++) begin
        words[k] = $random(seed);
      end
      if (n < NUM_SAMP) begin
        stb = 4'($random(seed));
      end
      // Most negative I on a conjugating channel
      if (n == 0) begin
        words[3] = 32'h8000_7FFF;
        stb[3]   = 1'b1;
      end
      i_rx_stb  <= stb;
      i_rx_data <= words;
      for (k = 0; k < radio_core_pkg::NUM_CHAN; k++) begin
        hist_stb[slot][k]  = stb[route_model[k]];
        hist_data[slot][k] = swap_iq(words[route_model[k]],
                                     ctrl_model.fields.conj_en[route_model[k]]);
      end
      // Outputs now reflect the drive of two edges ago
      @(negedge bus_clk);
      slot = (n + 1) % 3;
      if (o_tx_stb !== hist_stb[slot]) begin
        errors++;
        $display("[ERROR] o_tx_stb: expected %h got %h", hist_stb[slot], o_tx_stb);
      end
      for (k = 0; k < radio_core_pkg::NUM_CHAN; k++) begin
        if (hist_stb[slot][k] && o_tx_data[k] !== hist_data[slot][k]) begin
          errors++;
          $display("[ERROR] o_tx_data[%0d]: expected %h got %h",
                   k, hist_data[slot][k], o_tx_data[k]);
        end
      end
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    int i;
    seed          = 96989;
    errors        = 0;
    bus_rst       = 1'b1;
    i_reg_wr_req  = 1'b0;
    i_reg_wr_addr = '0;
    i_reg_wr_data = '0;
    i_reg_rd_req  = 1'b0;
    i_reg_rd_addr = '0;
    i_rx_data     = '0;
    i_rx_stb      = '0;
    ctrl_model.raw = radio_core_pkg::CTRL_RESET;
    for (i = 0; i < radio_core_pkg::NUM_CHAN; i++) begin
      route_model[i] = radio_core_pkg::ROUTE_WIDTH'(i);
    end
    repeat (RESET_CYCLES) @(posedge bus_clk);
    bus_rst <= 1'b0;
    @(negedge bus_clk);
    // State right after reset
    if (o_spi_mux !== 3'd2) begin
      errors++;
      $display("[ERROR] o_spi_mux: expected %h got %h", 3'd2, o_spi_mux);
    end
    if (o_cpld_reset !== 1'b0) begin
      errors++;
      $display("[ERROR] o_cpld_reset: expected %h got %h", 1'b0, o_cpld_reset);
    end
    if (o_reg_rd_resp !== 1'b0) begin
      errors++;
      $display("[ERROR] o_reg_rd_resp: expected %h got %h", 1'b0, o_reg_rd_resp);
    end
    if (o_tx_stb !== '0) begin
      errors++;
      $display("[ERROR] o_tx_stb: expected %h got %h", 4'h0, o_tx_stb);
    end
    for (i = 0; i < NUM_VEC; i++) begin
      @(posedge bus_clk);
      apply_vector(VEC_TABLE[i]);
    end
    run_samples();
    $display("Error count: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge bus_clk);
      cycle_cnt++;
    end
    $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Error count: %0d", errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
